// File: csr_pkg.sv
package csr_pkg;

    localparam int num_warps   = 4;
    localparam int nw_bits     = $clog2(num_warps);
    localparam int num_threads = 4;
    localparam int num_cores   = 2;
    localparam int core_id     = 1;

    localparam int csr_addr_bits    = 12;
    localparam int ffg_bits         = 5;
    localparam int frm_bits         = 3;
    localparam int fcsr_bits        = ffg_bits + frm_bits;
    localparam int commit_size_bits = 3;

    localparam logic [csr_addr_bits-1:0] csr_fflags = 12'h001;
    localparam logic [csr_addr_bits-1:0] csr_frm    = 12'h002;
    localparam logic [csr_addr_bits-1:0] csr_fcsr   = 12'h003;

    localparam logic [csr_addr_bits-1:0] csr_mstatus   = 12'h300;
    localparam logic [csr_addr_bits-1:0] csr_misa      = 12'h301;
    localparam logic [csr_addr_bits-1:0] csr_mie       = 12'h304;
    localparam logic [csr_addr_bits-1:0] csr_mtvec     = 12'h305;
    localparam logic [csr_addr_bits-1:0] csr_mscratch  = 12'h340;
    localparam logic [csr_addr_bits-1:0] csr_mepc      = 12'h341;
    localparam logic [csr_addr_bits-1:0] csr_mvendorid = 12'hF11;

    localparam logic [csr_addr_bits-1:0] csr_cycle     = 12'hC00;
    localparam logic [csr_addr_bits-1:0] csr_instret   = 12'hC02;
    localparam logic [csr_addr_bits-1:0] csr_cycle_h   = 12'hC80;
    localparam logic [csr_addr_bits-1:0] csr_instret_h = 12'hC82;

    // custom read-only identity registers.
    localparam logic [csr_addr_bits-1:0] csr_wid  = 12'hCC1;
    localparam logic [csr_addr_bits-1:0] csr_gwid = 12'hCC3;
    localparam logic [csr_addr_bits-1:0] csr_gcid = 12'hCC5;
    localparam logic [csr_addr_bits-1:0] csr_nt   = 12'hFC0;
    localparam logic [csr_addr_bits-1:0] csr_nw   = 12'hFC1;

    localparam logic [31:0] isa_code  = 32'h4000_1120; // rv32 with i, m and f.
    localparam logic [31:0] vendor_id = 32'h0000_0000;

    // the encoding follows funct3[1:0].
    typedef enum logic [1:0] {
        op_rw = 2'd1,
        op_rs = 2'd2,
        op_rc = 2'd3
    } csr_op_t;

    typedef struct packed {
        logic [nw_bits-1:0]       wid;
        logic [4:0]               rd;
        logic [4:0]               rs1;      // also the zimm field.
        logic [csr_addr_bits-1:0] addr;
        logic [2:0]               funct3;
        logic [31:0]              rs1_data;
    } csr_req_t;

    typedef struct packed {
        logic [nw_bits-1:0]       wid;
        logic [4:0]               rd;
        logic [csr_addr_bits-1:0] addr;
        csr_op_t                  op;
        logic [31:0]              operand;
        logic                     no_write;
    } csr_dec_t;

    typedef struct packed {
        logic [nw_bits-1:0] wid;
        logic [4:0]         rd;
        logic [31:0]        data;
    } csr_wb_t;

endpackage

// File: csr_decode.sv
`timescale 1ns/10ps

module csr_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  csr_pkg::csr_req_t  req,
    output logic               dec_valid,
    output csr_pkg::csr_dec_t  dec
);
    import csr_pkg::*;

    csr_dec_t dec_next;
    csr_op_t  op_next;
    logic     imm_form;

    assign imm_form = req.funct3[2];

    always_comb begin
        case (req.funct3[1:0])
            2'd2:    op_next = op_rs;
            2'd3:    op_next = op_rc;
            default: op_next = op_rw;
        endcase
    end

    always_comb begin
        dec_next.wid     = req.wid;
        dec_next.rd      = req.rd;
        dec_next.addr    = req.addr;
        dec_next.op      = op_next;
        dec_next.operand = imm_form ? 32'(req.rs1) : req.rs1_data;
        // set and clear with x0 or a zero immediate only read the register.
        dec_next.no_write = (op_next != op_rw) && (req.rs1 == 5'd0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    // the payload only moves with a new request, so the read address
    // seen by the CSR storage changes only when a request arrives.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec <= dec_next;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        req_valid |-> (req.funct3[1:0] != 2'd0))
    else $error("%t: csr_decode got a non-CSR funct3 %0d", $time, req.funct3);

endmodule

// File: csr_data.sv
`timescale 1ns/10ps

module csr_data (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [csr_pkg::csr_addr_bits-1:0]      read_addr,
    input  logic [csr_pkg::nw_bits-1:0]            read_wid,
    output logic [31:0]                            read_data,
    input  logic                                   write_enable,
    input  logic [csr_pkg::csr_addr_bits-1:0]      write_addr,
    input  logic [csr_pkg::nw_bits-1:0]            write_wid,
    input  logic [31:0]                            write_data,
    input  logic                                   busy,
    input  logic                                   commit_valid,
    input  logic [csr_pkg::commit_size_bits-1:0]   commit_size,
    input  logic                                   fflags_valid,
    input  logic [csr_pkg::nw_bits-1:0]            fflags_wid,
    input  logic [csr_pkg::ffg_bits-1:0]           fflags,
    input  logic [csr_pkg::nw_bits-1:0]            frm_wid,
    output logic [csr_pkg::frm_bits-1:0]           frm
);
    import csr_pkg::*;

    logic [num_warps-1:0][fcsr_bits-1:0] fcsr; // frm in the upper bits.
    logic [31:0] mstatus_r;
    logic [31:0] mie_r;
    logic [31:0] mtvec_r;
    logic [31:0] mepc_r;
    logic [31:0] mscratch_r;
    logic [63:0] cycle_cnt;
    logic [63:0] instret_cnt;
    logic        write_ok;
    logic        read_hit;

    assign write_ok = write_addr inside {csr_fflags, csr_frm, csr_fcsr, csr_mstatus,
                                         csr_mie, csr_mtvec, csr_mepc, csr_mscratch};

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr       <= '0;
            mstatus_r  <= '0;
            mie_r      <= '0;
            mtvec_r    <= '0;
            mepc_r     <= '0;
            mscratch_r <= '0;
        end else begin
            if (fflags_valid) begin
                fcsr[fflags_wid][ffg_bits-1:0] <= fcsr[fflags_wid][ffg_bits-1:0] | fflags;
            end
            // a CSR write comes last so it wins over the FPU on the same field.
            if (write_enable) begin
                case (write_addr)
                    csr_fflags:   fcsr[write_wid][ffg_bits-1:0] <= write_data[ffg_bits-1:0];
                    csr_frm:      fcsr[write_wid][fcsr_bits-1:ffg_bits] <= write_data[frm_bits-1:0];
                    csr_fcsr:     fcsr[write_wid] <= write_data[fcsr_bits-1:0];
                    csr_mstatus:  mstatus_r  <= write_data;
                    csr_mie:      mie_r      <= write_data;
                    csr_mtvec:    mtvec_r    <= write_data;
                    csr_mepc:     mepc_r     <= write_data;
                    csr_mscratch: mscratch_r <= write_data;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt   <= '0;
            instret_cnt <= '0;
        end else begin
            if (busy) begin
                cycle_cnt <= cycle_cnt + 64'd1;
            end
            if (commit_valid) begin
                instret_cnt <= instret_cnt + 64'(commit_size);
            end
        end
    end

    always_comb begin
        read_hit  = 1'b1;
        read_data = '0;
        case (read_addr)
            csr_fflags:    read_data = 32'(fcsr[read_wid][ffg_bits-1:0]);
            csr_frm:       read_data = 32'(fcsr[read_wid][fcsr_bits-1:ffg_bits]);
            csr_fcsr:      read_data = 32'(fcsr[read_wid]);
            csr_wid:       read_data = 32'(read_wid);
            csr_gwid:      read_data = 32'(core_id * num_warps) + 32'(read_wid);
            csr_gcid:      read_data = 32'(core_id);
            csr_nt:        read_data = 32'(num_threads);
            csr_nw:        read_data = 32'(num_warps);
            csr_mstatus:   read_data = mstatus_r;
            csr_misa:      read_data = isa_code;
            csr_mie:       read_data = mie_r;
            csr_mtvec:     read_data = mtvec_r;
            csr_mepc:      read_data = mepc_r;
            csr_mscratch:  read_data = mscratch_r;
            csr_mvendorid: read_data = vendor_id;
            csr_cycle:     read_data = cycle_cnt[31:0];
            csr_cycle_h:   read_data = cycle_cnt[63:32];
            csr_instret:   read_data = instret_cnt[31:0];
            csr_instret_h: read_data = instret_cnt[63:32];
            default:       read_hit  = 1'b0;
        endcase
    end

    assign frm = fcsr[frm_wid][fcsr_bits-1:ffg_bits]; // FPU port, no pipeline delay.

    assert property (@(posedge clk) disable iff (reset) write_enable |-> write_ok)
    else $error("%t: csr_data write to read-only or unknown CSR %h", $time, write_addr);

    // the read address follows the decode payload, which moves only on a request.
    assert property (@(posedge clk) disable iff (reset) $changed(read_addr) |-> read_hit)
    else $error("%t: csr_data read of unknown CSR %h", $time, read_addr);

endmodule

// File: csr_execute.sv
`timescale 1ns/10ps

module csr_execute (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 dec_valid,
    input  csr_pkg::csr_dec_t                    dec,
    output logic                                 exe_valid,
    output csr_pkg::csr_wb_t                     exe,
    input  logic                                 busy,
    input  logic                                 commit_valid,
    input  logic [csr_pkg::commit_size_bits-1:0] commit_size,
    input  logic                                 fflags_valid,
    input  logic [csr_pkg::nw_bits-1:0]          fflags_wid,
    input  logic [csr_pkg::ffg_bits-1:0]         fflags,
    input  logic [csr_pkg::nw_bits-1:0]          frm_wid,
    output logic [csr_pkg::frm_bits-1:0]         frm
);
    import csr_pkg::*;

    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        write_enable;

    assign write_enable = dec_valid && !dec.no_write;

    always_comb begin
        case (dec.op)
            op_rs:   new_value = old_value | dec.operand;
            op_rc:   new_value = old_value & ~dec.operand;
            default: new_value = dec.operand;
        endcase
    end

    csr_data i_csr_data (
        .clk          (clk),
        .reset        (reset),
        .read_addr    (dec.addr),
        .read_wid     (dec.wid),
        .read_data    (old_value),
        .write_enable (write_enable),
        .write_addr   (dec.addr),
        .write_wid    (dec.wid),
        .write_data   (new_value),
        .busy         (busy),
        .commit_valid (commit_valid),
        .commit_size  (commit_size),
        .fflags_valid (fflags_valid),
        .fflags_wid   (fflags_wid),
        .fflags       (fflags),
        .frm_wid      (frm_wid),
        .frm          (frm)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe.wid  <= dec.wid;
            exe.rd   <= dec.rd;
            exe.data <= old_value; // the instruction returns the value before the write.
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (dec_valid |=> exe_valid) and (!dec_valid |=> !exe_valid))
    else $error("%t: csr_execute valid did not follow decode by one cycle", $time);

endmodule

// File: csr_result.sv
`timescale 1ns/10ps

module csr_result (
    input  logic              clk,
    input  logic              reset,
    input  logic              exe_valid,
    input  csr_pkg::csr_wb_t  exe,
    output logic              wb_valid,
    output csr_pkg::csr_wb_t  wb
);
    import csr_pkg::*;

    logic writes_reg;

    // x0 is hardwired to zero, so a CSR result aimed at it is dropped.
    assign writes_reg = exe_valid && (exe.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= writes_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (writes_reg) begin
            wb <= exe;
        end
    end

endmodule

// File: csr_unit.sv
`timescale 1ns/10ps

module csr_unit (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 req_valid,
    input  csr_pkg::csr_req_t                    req,
    input  logic                                 busy,
    input  logic                                 commit_valid,
    input  logic [csr_pkg::commit_size_bits-1:0] commit_size,
    input  logic                                 fflags_valid,
    input  logic [csr_pkg::nw_bits-1:0]          fflags_wid,
    input  logic [csr_pkg::ffg_bits-1:0]         fflags,
    input  logic [csr_pkg::nw_bits-1:0]          frm_wid,
    output logic [csr_pkg::frm_bits-1:0]         frm,
    output logic                                 wb_valid,
    output csr_pkg::csr_wb_t                     wb
);
    import csr_pkg::*;

    logic     dec_valid;
    csr_dec_t dec;
    logic     exe_valid;
    csr_wb_t  exe;

    csr_decode i_csr_decode (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    csr_execute i_csr_execute (
        .clk          (clk),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .exe_valid    (exe_valid),
        .exe          (exe),
        .busy         (busy),
        .commit_valid (commit_valid),
        .commit_size  (commit_size),
        .fflags_valid (fflags_valid),
        .fflags_wid   (fflags_wid),
        .fflags       (fflags),
        .frm_wid      (frm_wid),
        .frm          (frm)
    );

    csr_result i_csr_result (
        .clk       (clk),
        .reset     (reset),
        .exe_valid (exe_valid),
        .exe       (exe),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

endmodule

// File: tb_csr_unit.sv
`timescale 1ns/10ps

module tb_csr_unit;
    import csr_pkg::*;

    typedef struct packed {
        logic [31:0]        due;
        logic [nw_bits-1:0] wid;
        logic [4:0]         rd;
        logic [31:0]        data;
    } expect_t;

    logic                        clk;
    logic                        reset;
    logic                        req_valid;
    csr_req_t                    req;
    logic                        busy;
    logic                        commit_valid;
    logic [commit_size_bits-1:0] commit_size;
    logic                        fflags_valid;
    logic [nw_bits-1:0]          fflags_wid;
    logic [ffg_bits-1:0]         fflags;
    logic [nw_bits-1:0]          frm_wid;
    logic [frm_bits-1:0]         frm;
    logic                        wb_valid;
    csr_wb_t                     wb;

    logic [ffg_bits-1:0] m_flags [num_warps];
    logic [frm_bits-1:0] m_frm [num_warps];
    logic [31:0]         m_reg [logic [csr_addr_bits-1:0]]; // machine registers, zero until written.
    logic [63:0]         m_cycles;
    logic [63:0]         m_instret;
    logic                exe_pend;    // a request reaches the execute stage at the next edge.
    csr_req_t            exe_req;
    logic [31:0]         exe_lit;
    logic                exe_use_lit;
    logic [31:0]         tick = '0;
    expect_t             exp_q [$];
    int                  value_errors;
    int                  other_errors;

    csr_unit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        tick <= tick + 32'd1;
    end

    function automatic logic [31:0] model_read(input logic [csr_addr_bits-1:0] addr,
                                               input logic [nw_bits-1:0] wid);
        case (addr)
            csr_fflags:    return 32'(m_flags[wid]);
            csr_frm:       return 32'(m_frm[wid]);
            csr_fcsr:      return 32'({m_frm[wid], m_flags[wid]});
            csr_cycle:     return m_cycles[31:0];
            csr_cycle_h:   return m_cycles[63:32];
            csr_instret:   return m_instret[31:0];
            csr_instret_h: return m_instret[63:32];
            default:       return m_reg.exists(addr) ? m_reg[addr] : 32'd0;
        endcase
    endfunction

    // called at a falling edge once the inputs are driven, it applies the next rising edge.
    task automatic model_edge(input logic [31:0] lit, input logic use_lit);
        logic [31:0] old_v;
        logic [31:0] opnd;
        logic [31:0] new_v;
        expect_t     e;
        if (exe_pend) begin
            old_v = model_read(exe_req.addr, exe_req.wid);
            opnd  = exe_req.funct3[2] ? 32'(exe_req.rs1) : exe_req.rs1_data;
            case (exe_req.funct3[1:0])
                2'd2:    new_v = old_v | opnd;
                2'd3:    new_v = old_v & ~opnd;
                default: new_v = opnd;
            endcase
            e.due  = tick + 32'd2;
            e.wid  = exe_req.wid;
            e.rd   = exe_req.rd;
            e.data = exe_use_lit ? exe_lit : old_v;
            if (exe_req.rd != 5'd0) exp_q.push_back(e);
        end
        if (fflags_valid) m_flags[fflags_wid] = m_flags[fflags_wid] | fflags;
        if (exe_pend && (exe_req.funct3[1:0] == 2'd1 || exe_req.rs1 != 5'd0)) begin
            case (exe_req.addr) // applied after the FPU so the CSR write wins.
                csr_fflags: m_flags[exe_req.wid] = new_v[ffg_bits-1:0];
                csr_frm:    m_frm[exe_req.wid] = new_v[frm_bits-1:0];
                csr_fcsr: begin
                    m_flags[exe_req.wid] = new_v[ffg_bits-1:0];
                    m_frm[exe_req.wid]   = new_v[ffg_bits+frm_bits-1:ffg_bits];
                end
                default:    m_reg[exe_req.addr] = new_v;
            endcase
        end
        if (busy) m_cycles = m_cycles + 64'd1;
        if (commit_valid) m_instret = m_instret + 64'(commit_size);
        exe_pend    = req_valid;
        exe_req     = req;
        exe_lit     = lit;
        exe_use_lit = use_lit;
    endtask

    task automatic idle_inputs();
        req_valid    = 1'b0;
        fflags_valid = 1'b0;
        commit_valid = 1'b0;
        busy         = ($urandom % 4) != 0;
    endtask

    // a set with x0 only reads, so the model supplies the expected value.
    task automatic issue_read(input logic [csr_addr_bits-1:0] csr,
                              input logic [nw_bits-1:0] warp,
                              input logic [4:0] dest);
        @(negedge clk);
        idle_inputs();
        req_valid = 1'b1;
        req = '{wid: warp, rd: dest, rs1: 5'd0, addr: csr, funct3: 3'd2, rs1_data: 32'd0};
        model_edge('0, 1'b0);
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (!reset && wb_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("unexpected writeback at %0t for rd %0d", $time, wb.rd);
                other_errors++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                assert (e.due == tick) else begin
                    $display("writeback for rd %0d came at edge %0d instead of edge %0d",
                             wb.rd, tick, e.due);
                    other_errors++;
                end
                assert (wb.data == e.data && wb.rd == e.rd && wb.wid == e.wid) else begin
                    $display("FAILED %0t: wid %0d rd %0d data %h, expected wid %0d rd %0d data %h",
                             $time, wb.wid, wb.rd, wb.data, e.wid, e.rd, e.data);
                    value_errors++;
                end
            end
        end else if (!reset) begin
            assert (exp_q.size() == 0 || exp_q[0].due > tick) else begin
                $display("no writeback for rd %0d at edge %0d", exp_q[0].rd, exp_q[0].due);
                other_errors++;
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        string       line;
        int          fd;
        int          n;
        int          timeout;
        logic [7:0]  kind;
        logic        prev_r;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        busy         = 1'b0;
        commit_valid = 1'b0;
        commit_size  = '0;
        fflags_valid = 1'b0;
        fflags_wid   = '0;
        fflags       = '0;
        frm_wid      = '0;
        m_flags      = '{default: '0};
        m_frm        = '{default: '0};
        m_cycles     = '0;
        m_instret    = '0;
        exe_pend     = 1'b0;
        exe_req      = '0;
        value_errors = 0;
        other_errors = 0;
        prev_r       = 1'b0;
        void'($urandom(32'he7e6_63a1));
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        fd = $fopen("csr_trace.txt", "r");
        assert (fd != 0) else begin
            $display("could not open csr_trace.txt");
            other_errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;
            kind = line.getc(0);
            n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h %h",
                        f0, f1, f2, f3, f4, f5, f6);
            // gaps never split a run of requests or an FPU update from the request before it.
            if (kind == "C" || (kind == "R" && !prev_r)) begin
                repeat ($urandom % 3) begin
                    @(negedge clk);
                    idle_inputs();
                    model_edge('0, 1'b0);
                end
            end
            @(negedge clk);
            idle_inputs();
            case (kind)
                "R": begin
                    req_valid = 1'b1;
                    req = '{wid: f0[nw_bits-1:0], rd: f1[4:0], rs1: f2[4:0],
                            addr: f3[csr_addr_bits-1:0], funct3: f4[2:0], rs1_data: f5};
                end
                "F": begin
                    fflags_valid = 1'b1;
                    fflags_wid   = f0[nw_bits-1:0];
                    fflags       = f1[ffg_bits-1:0];
                end
                "C": begin
                    commit_valid = 1'b1;
                    commit_size  = f0[commit_size_bits-1:0];
                end
                "M": begin
                    frm_wid = f0[nw_bits-1:0];
                    #1;
                    assert (frm == f1[frm_bits-1:0]) else begin
                        $display("FAILED %0t: frm of warp %0d is %0d, expected %0d",
                                 $time, frm_wid, frm, f1[frm_bits-1:0]);
                        value_errors++;
                    end
                end
                default: begin
                    $display("unknown event in trace line: %s", line);
                    other_errors++;
                end
            endcase
            model_edge(f6, kind == "R" && n == 7);
            prev_r = (kind == "R");
        end
        if (fd != 0) $fclose(fd);
        // the last value written to each register and to each warp's fcsr is read back.
        issue_read(csr_mstatus, '0, 5'd1);
        issue_read(csr_mie, '0, 5'd2);
        issue_read(csr_mtvec, '0, 5'd3);
        issue_read(csr_mepc, '0, 5'd4);
        issue_read(csr_mscratch, '0, 5'd5);
        for (int w = 0; w < num_warps; w++) begin
            issue_read(csr_fcsr, nw_bits'(w), 5'd6);
        end
        timeout = 0;
        while ((exe_pend || exp_q.size() > 0) && timeout < 50) begin
            @(negedge clk);
            idle_inputs();
            model_edge('0, 1'b0);
            timeout++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timed out waiting for %0d writebacks", exp_q.size());
            other_errors++;
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: csr_trace.txt
# R wid rd rs1 addr funct3 rs1_data expect, where an expect of - takes the value from the model
# F wid fflags, C commit_size, M wid expected_frm; every field is hex
R 0 05 01 300 1 00001888 -
R 0 06 03 300 2 00000007 -
R 0 07 04 300 3 00000800 -
R 0 08 00 300 2 ffffffff -
R 0 09 1f 305 5 00000000 -
R 0 0a 0a 305 7 00000000 -
R 0 00 12 341 6 00000000 -
R 0 0b 00 341 1 deadbeef -
R 0 0c 00 341 3 00000000 -
R 1 0d 00 340 1 a5a5a5a5 -
R 1 0e 01 304 1 00000888 -
F 1 05
F 1 02
R 1 0f 00 001 2 00000000 -
R 2 10 03 002 5 00000000 -
R 2 11 01 001 5 00000000 -
F 2 10
R 3 12 05 003 1 000000e5 -
R 2 13 00 003 2 00000000 -
M 2 3
M 3 7
C 5
C 7
R 1 14 00 c00 2 00000000 -
R 1 15 00 c80 2 00000000 -
R 1 16 00 c02 2 00000000 -
R 1 17 00 c82 2 00000000 -
R 2 18 00 cc1 2 00000000 00000002
R 2 19 00 cc3 2 00000000 00000006
R 0 1a 00 cc5 2 00000000 00000001
R 0 1b 00 fc0 2 00000000 00000004
R 0 1c 00 fc1 2 00000000 00000004
R 0 1d 00 301 2 00000000 40001120
R 0 1e 00 f11 2 00000000 00000000
R 0 1f 00 300 2 00000000 -

// File: list.f
csr_pkg.sv
csr_decode.sv
csr_data.sv
csr_execute.sv
csr_result.sv
csr_unit.sv
tb_csr_unit.sv

// File: run.sh
#!/bin/sh
# builds the CSR unit testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_csr_unit -f list.f
./obj_dir/Vtb_csr_unit > sim.log 2>&1 || true
cat sim.log
if grep -q '^RESULT: PASS$' sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
